// File: rtl/dlxPkg.sv
package dlxPkg;

    ////////////////////
    // basic types
    ////////////////////

    // data words keep the big-endian numbering of the instruction set
    typedef logic [0:31] wordT;
    typedef logic [0:4]  regIdxT;

    // the one instruction word that is decoded as a trap
    localparam wordT   TRAP_WORD = 32'h44000300;
    // jal links through r31
    localparam regIdxT LINK_REG  = 5'd31;

    ////////////////////
    // encodings
    ////////////////////

    // primary opcode, instruction bits 0 to 5
    typedef enum logic [5:0] {
        OP_RTYPE = 6'h00,
        OP_JAL   = 6'h03,
        OP_ADDI  = 6'h08,
        OP_SUBI  = 6'h0a,
        OP_ANDI  = 6'h0c,
        OP_ORI   = 6'h0d,
        OP_XORI  = 6'h0e,
        OP_LHI   = 6'h0f,
        OP_TRAP  = 6'h11,
        OP_SLLI  = 6'h14
    } opcodeT;

    // r-type function, instruction bits 26 to 31
    typedef enum logic [5:0] {
        FN_SLL = 6'h04,
        FN_SRL = 6'h06,
        FN_ADD = 6'h20,
        FN_SUB = 6'h22,
        FN_AND = 6'h24,
        FN_OR  = 6'h25,
        FN_XOR = 6'h26,
        FN_SLT = 6'h2a
    } funcT;

    typedef enum logic [3:0] {
        ALU_ADD, ALU_SUB, ALU_AND, ALU_OR, ALU_XOR, ALU_SLL, ALU_SRL, ALU_SLT
    } aluOpT;

    ////////////////////
    // stage payloads
    ////////////////////

    typedef struct packed {
        logic  rType;
        logic  extOp;
        logic  lhiOp;
        logic  pcToReg;
        logic  regWrite;
        aluOpT aluOp;
    } ctrlT;

    // core input, one instruction with the pc of its successor
    typedef struct packed {
        wordT instruction;
        wordT nextPC;
    } instT;

    // decode to execute
    typedef struct packed {
        wordT   opA;
        wordT   opB;
        wordT   nextPC;
        aluOpT  aluOp;
        logic   pcToReg;
        regIdxT destReg;
        logic   regWrite;
        logic   trap;
    } execT;

    // execute to result, and the core output
    typedef struct packed {
        regIdxT destReg;
        wordT   value;
        logic   regWrite;
        logic   trap;
    } resultT;

endpackage

// File: rtl/controlUnit.sv
`timescale 1ns/1ps

module controlUnit (
    input  dlxPkg::wordT instruction,
    output dlxPkg::ctrlT ctrl
);
    import dlxPkg::*;

    opcodeT opcode;
    funcT   func;

    // opcode sits in the top bits, func in the bottom bits
    assign opcode = opcodeT'(instruction[0:5]);
    assign func   = funcT'(instruction[26:31]);

    always_comb begin
        // defaults describe a no-op that adds and writes nothing
        ctrl = '{rType: 1'b0, extOp: 1'b0, lhiOp: 1'b0, pcToReg: 1'b0,
                 regWrite: 1'b0, aluOp: ALU_ADD};
        case (opcode)
            OP_RTYPE: begin
                ctrl.rType    = 1'b1;
                ctrl.regWrite = 1'b1;
                case (func)
                    FN_ADD:  ctrl.aluOp = ALU_ADD;
                    FN_SUB:  ctrl.aluOp = ALU_SUB;
                    FN_AND:  ctrl.aluOp = ALU_AND;
                    FN_OR:   ctrl.aluOp = ALU_OR;
                    FN_XOR:  ctrl.aluOp = ALU_XOR;
                    FN_SLL:  ctrl.aluOp = ALU_SLL;
                    FN_SRL:  ctrl.aluOp = ALU_SRL;
                    FN_SLT:  ctrl.aluOp = ALU_SLT;
                    // unknown func retires without a write
                    default: ctrl.regWrite = 1'b0;
                endcase
            end
            // only the arithmetic immediates sign extend
            OP_ADDI: begin
                ctrl.extOp    = 1'b1;
                ctrl.regWrite = 1'b1;
            end
            OP_SUBI: begin
                ctrl.extOp    = 1'b1;
                ctrl.regWrite = 1'b1;
                ctrl.aluOp    = ALU_SUB;
            end
            OP_ANDI: begin
                ctrl.regWrite = 1'b1;
                ctrl.aluOp    = ALU_AND;
            end
            OP_ORI: begin
                ctrl.regWrite = 1'b1;
                ctrl.aluOp    = ALU_OR;
            end
            OP_XORI: begin
                ctrl.regWrite = 1'b1;
                ctrl.aluOp    = ALU_XOR;
            end
            OP_SLLI: begin
                ctrl.regWrite = 1'b1;
                ctrl.aluOp    = ALU_SLL;
            end
            // lhi is imm16 shifted left by the constant 16
            OP_LHI: begin
                ctrl.lhiOp    = 1'b1;
                ctrl.regWrite = 1'b1;
                ctrl.aluOp    = ALU_SLL;
            end
            // link value comes from nextPC, alu result is ignored
            OP_JAL: begin
                ctrl.pcToReg  = 1'b1;
                ctrl.regWrite = 1'b1;
            end
            default: ctrl.regWrite = 1'b0;
        endcase
    end

endmodule

// File: rtl/regFile.sv
`timescale 1ns/1ps

module regFile (
    input  logic           clk,
    input  logic           rstN,
    input  dlxPkg::regIdxT rdIdxA,
    input  dlxPkg::regIdxT rdIdxB,
    output dlxPkg::wordT   rdDataA,
    output dlxPkg::wordT   rdDataB,
    input  logic           wrEn,
    input  dlxPkg::regIdxT wrIdx,
    input  dlxPkg::wordT   wrData
);
    import dlxPkg::*;

    wordT regs [0:31];

    ////////////////////
    // write port
    ////////////////////

    always_ff @(posedge clk) begin
        if (!rstN) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (wrEn && (wrIdx != '0)) begin
            // r0 is never written
            regs[wrIdx] <= wrData;
        end
    end

    ////////////////////
    // read ports
    ////////////////////

    // combinational, r0 always reads as zero
    assign rdDataA = (rdIdxA == '0) ? '0 : regs[rdIdxA];
    assign rdDataB = (rdIdxB == '0) ? '0 : regs[rdIdxB];

    // a write lands at the clock edge, the reader sees it the cycle after

endmodule

// File: rtl/decodeStage.sv
`timescale 1ns/1ps

module decodeStage (
    input  logic           instValid,
    output logic           instReady,
    input  dlxPkg::instT   inst,
    output dlxPkg::regIdxT rdIdxA,
    output dlxPkg::regIdxT rdIdxB,
    input  dlxPkg::wordT   rdDataA,
    input  dlxPkg::wordT   rdDataB,
    input  dlxPkg::regIdxT exDest,
    input  dlxPkg::regIdxT resDest,
    input  logic           exWrite,
    input  logic           resWrite,
    output logic           execValid,
    input  logic           execReady,
    output dlxPkg::execT   exec
);
    import dlxPkg::*;

    ctrlT        ctrl;
    regIdxT      r1;
    regIdxT      r2;
    regIdxT      rd;
    logic [0:15] imm16;
    wordT        immExt;
    logic        trap;
    logic        hazA;
    logic        hazB;
    logic        stall;

    controlUnit ctrlUnit (
        .instruction(inst.instruction),
        .ctrl       (ctrl)
    );

    ////////////////////
    // field split
    ////////////////////

    assign r1    = inst.instruction[6:10];
    assign r2    = inst.instruction[11:15];
    assign rd    = inst.instruction[16:20];
    assign imm16 = inst.instruction[16:31];

    // register file is addressed straight from the instruction
    assign rdIdxA = r1;
    assign rdIdxB = r2;

    // extOp picks sign extension, otherwise zero fill
    assign immExt = ctrl.extOp ? {{16{imm16[0]}}, imm16} : {16'b0, imm16};

    // exact compare against the whole trap word
    assign trap = (inst.instruction == TRAP_WORD);

    ////////////////////
    // hazard check
    ////////////////////

    // r1 is always checked, r2 only when r-type reads it
    assign hazA = (exWrite && (exDest != '0) && (exDest == r1)) ||
                  (resWrite && (resDest != '0) && (resDest == r1));
    assign hazB = ctrl.rType &&
                  ((exWrite && (exDest != '0) && (exDest == r2)) ||
                   (resWrite && (resDest != '0) && (resDest == r2)));
    assign stall = instValid && (hazA || hazB);

    // a stalled instruction neither leaves nor is accepted
    assign execValid = instValid && !stall;
    assign instReady = execReady && !stall;

    ////////////////////
    // operands
    ////////////////////

    // opB is register for r-type, 16 for lhi, else extended immediate
    assign exec.opB = ctrl.rType ? rdDataB : (ctrl.lhiOp ? 32'd16 : immExt);
    // lhi shifts the zero extended immediate in opA
    assign exec.opA = ctrl.lhiOp ? {16'b0, imm16} : rdDataA;

    assign exec.nextPC  = inst.nextPC;
    assign exec.aluOp   = ctrl.aluOp;
    assign exec.pcToReg = ctrl.pcToReg;
    // rd for r-type, r2 otherwise, r31 for jal
    assign exec.destReg = ctrl.pcToReg ? LINK_REG : (ctrl.rType ? rd : r2);
    // trap never writes back
    assign exec.regWrite = ctrl.regWrite && !trap;
    assign exec.trap     = trap;

endmodule

// File: rtl/stageReg.sv
`timescale 1ns/1ps

module stageReg #(
    parameter type payloadT = logic [31:0]
) (
    input  logic    clk,
    input  logic    rstN,
    input  logic    inValid,
    output logic    inReady,
    input  payloadT inData,
    output logic    outValid,
    input  logic    outReady,
    output payloadT outData
);

    logic    validQ;
    payloadT dataQ;

    // free slot, or the held item leaves this cycle
    assign inReady = !validQ || outReady;

    always_ff @(posedge clk) begin
        if (!rstN) begin
            validQ <= 1'b0;
        end else if (inReady) begin
            // refill on the same edge the old item drains
            validQ <= inValid;
        end
    end

    // payload only moves on an input transfer
    always_ff @(posedge clk) begin
        if (inValid && inReady) begin
            dataQ <= inData;
        end
    end

    assign outValid = validQ;
    assign outData  = dataQ;

endmodule

// File: rtl/executeStage.sv
`timescale 1ns/1ps

module executeStage (
    input  logic           execValid,
    output logic           execReady,
    input  dlxPkg::execT   exec,
    output logic           resValid,
    input  logic           resReady,
    output dlxPkg::resultT res
);
    import dlxPkg::*;

    logic [4:0] shamt;
    logic       lessThan;
    wordT       aluResult;
    wordT       value;

    ////////////////////
    // alu
    ////////////////////

    // shifts use only the low five bits of opB
    assign shamt    = exec.opB[27:31];
    assign lessThan = $signed(exec.opA) < $signed(exec.opB);

    always_comb begin
        case (exec.aluOp)
            ALU_ADD: aluResult = exec.opA + exec.opB;
            ALU_SUB: aluResult = exec.opA - exec.opB;
            ALU_AND: aluResult = exec.opA & exec.opB;
            ALU_OR:  aluResult = exec.opA | exec.opB;
            ALU_XOR: aluResult = exec.opA ^ exec.opB;
            ALU_SLL: aluResult = exec.opA << shamt;
            // logical shift, zero fill from the top
            ALU_SRL: aluResult = exec.opA >> shamt;
            ALU_SLT: aluResult = {31'b0, lessThan};
            default: aluResult = '0;
        endcase
    end

    // jal writes the link address instead of the alu result
    assign value = exec.pcToReg ? exec.nextPC : aluResult;

    ////////////////////
    // result stream
    ////////////////////

    // purely combinational, handshake passes straight through
    assign resValid  = execValid;
    assign execReady = resReady;

    assign res = '{
        destReg:  exec.destReg,
        value:    value,
        regWrite: exec.regWrite,
        trap:     exec.trap
    };

endmodule

// File: rtl/resultStage.sv
`timescale 1ns/1ps

module resultStage (
    input  logic           inValid,
    output logic           inReady,
    input  dlxPkg::resultT inData,
    output logic           resValid,
    input  logic           resReady,
    output dlxPkg::resultT res,
    output logic           wrEn,
    output dlxPkg::regIdxT wrIdx,
    output dlxPkg::wordT   wrData
);

    logic xfer;

    ////////////////////
    // output stream
    ////////////////////

    // retired result is presented as held by the stage register
    assign resValid = inValid;
    assign inReady  = resReady;
    assign res      = inData;

    ////////////////////
    // write back
    ////////////////////

    // commit only on the handshake edge, so a held result writes once
    assign xfer   = inValid && resReady;
    assign wrEn   = xfer && inData.regWrite;
    assign wrIdx  = inData.destReg;
    assign wrData = inData.value;

    // traps and no-ops arrive with regWrite low and only retire

endmodule

// File: rtl/dlxCore.sv
`timescale 1ns/1ps

module dlxCore (
    input  logic           clk,
    input  logic           rstN,
    input  logic           instValid,
    output logic           instReady,
    input  dlxPkg::instT   inst,
    output logic           resValid,
    input  logic           resReady,
    output dlxPkg::resultT res
);
    import dlxPkg::*;

    regIdxT rdIdxA;
    regIdxT rdIdxB;
    wordT   rdDataA;
    wordT   rdDataB;

    // decode to decExReg
    logic   decValid;
    logic   decReady;
    execT   decData;
    // decExReg to execute
    logic   exValid;
    logic   exReady;
    execT   exData;
    // execute to exResReg
    logic   aluValid;
    logic   aluReady;
    resultT aluData;
    // exResReg to result
    logic   retValid;
    logic   retReady;
    resultT retData;

    logic   wrEn;
    regIdxT wrIdx;
    wordT   wrData;

    ////////////////////
    // decode
    ////////////////////

    // hazard inputs only count while the stage register holds an item
    decodeStage decStage (
        .instValid(instValid),          .instReady(instReady),
        .inst     (inst),
        .rdIdxA   (rdIdxA),             .rdIdxB   (rdIdxB),
        .rdDataA  (rdDataA),            .rdDataB  (rdDataB),
        .exDest   (exData.destReg),     .resDest  (retData.destReg),
        .exWrite  (exValid && exData.regWrite),
        .resWrite (retValid && retData.regWrite),
        .execValid(decValid),           .execReady(decReady),
        .exec     (decData)
    );

    stageReg #(.payloadT(execT)) decExReg (
        .clk     (clk),      .rstN    (rstN),
        .inValid (decValid), .inReady (decReady), .inData (decData),
        .outValid(exValid),  .outReady(exReady),  .outData(exData)
    );

    ////////////////////
    // execute and result
    ////////////////////

    executeStage exStage (
        .execValid(exValid),  .execReady(exReady),  .exec(exData),
        .resValid (aluValid), .resReady (aluReady), .res (aluData)
    );

    stageReg #(.payloadT(resultT)) exResReg (
        .clk     (clk),      .rstN    (rstN),
        .inValid (aluValid), .inReady (aluReady), .inData (aluData),
        .outValid(retValid), .outReady(retReady), .outData(retData)
    );

    resultStage resStage (
        .inValid (retValid), .inReady (retReady), .inData(retData),
        .resValid(resValid), .resReady(resReady), .res   (res),
        .wrEn    (wrEn),     .wrIdx   (wrIdx),    .wrData(wrData)
    );

    regFile rf (
        .clk    (clk),     .rstN   (rstN),
        .rdIdxA (rdIdxA),  .rdIdxB (rdIdxB),
        .rdDataA(rdDataA), .rdDataB(rdDataB),
        .wrEn   (wrEn),    .wrIdx  (wrIdx),  .wrData(wrData)
    );

endmodule

// File: sim/clockGen.sv
`timescale 1ns/1ps

module clockGen (
    output logic clk,
    output logic rstN
);

    // 8 ns period, first rising edge at 4 ns
    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    // reset held low over two rising edges, released on a falling edge
    initial begin
        rstN = 1'b0;
        repeat (2) @(posedge clk);
        @(negedge clk);
        rstN = 1'b1;
    end

endmodule

// File: sim/tbDlxCore.sv
`timescale 1ns/1ps

module tbDlxCore;
    import dlxPkg::*;

    localparam int MAX_TESTS       = 64;
    // watchdog budget for each stimulus line
    localparam int CYCLES_PER_TEST = 40;
    // quiet cycles after the last result, so a stray extra result is caught
    localparam int DRAIN_CYCLES    = 8;

    logic   clk;
    logic   rstN;
    logic   instValid;
    logic   instReady;
    instT   inst;
    logic   resValid;
    logic   resReady;
    resultT res;

    // one entry per stimulus line
    string  testName [MAX_TESTS];
    wordT   stimInst [MAX_TESTS];
    wordT   stimPC   [MAX_TESTS];
    regIdxT expDest  [MAX_TESTS];
    wordT   expValue [MAX_TESTS];
    logic   expTrap  [MAX_TESTS];

    int numTests = 0;
    int driveIdx = 0;
    int resIdx   = 0;
    int okCount  = 0;
    int badCount = 0;
    int errCount = 0;
    int seed     = 85755;
    bit loaded   = 1'b0;

    clockGen clkGen (
        .clk (clk),
        .rstN(rstN)
    );

    dlxCore UUT (
        .clk      (clk),
        .rstN     (rstN),
        .instValid(instValid),
        .instReady(instReady),
        .inst     (inst),
        .resValid (resValid),
        .resReady (resReady),
        .res      (res)
    );

    ////////////////////
    // helpers
    ////////////////////

    // columns: name, instruction, nextPC, dest, value, trap
    task automatic loadStim();
        int    fd;
        int    n;
        int    dst;
        int    trp;
        string line;
        string name;
        wordT  ins;
        wordT  pc;
        wordT  val;
        fd = $fopen("sim/dlxStim.txt", "r");
        assert (fd != 0) else begin
            $display("cannot open the stimulus file sim/dlxStim.txt");
            errCount++;
        end
        if (fd != 0) begin
            while (!$feof(fd) && (numTests < MAX_TESTS)) begin
                line = "";
                n = $fgets(line, fd);
                // hash lines describe the columns
                if ((line.len() > 0) && (line[0] != "#")) begin
                    n = $sscanf(line, "%s %h %h %d %h %d", name, ins, pc, dst, val, trp);
                    if (n == 6) begin
                        testName[numTests] = name;
                        stimInst[numTests] = ins;
                        stimPC[numTests]   = pc;
                        expDest[numTests]  = regIdxT'(dst);
                        expValue[numTests] = val;
                        expTrap[numTests]  = (trp != 0);
                        numTests++;
                    end
                end
            end
            $fclose(fd);
        end
        assert (numTests > 0) else begin
            $display("no test lines were read from the stimulus file");
            errCount++;
        end
    endtask

    // high for instructions of the set that write a register
    function automatic logic writesReg(wordT ins);
        logic wr;
        case (ins[0:5])
            // r-type writes only with a known function
            6'h00: begin
                case (ins[26:31])
                    6'h04, 6'h06, 6'h20, 6'h22, 6'h24, 6'h25, 6'h26, 6'h2a: wr = 1'b1;
                    default: wr = 1'b0;
                endcase
            end
            // jal and the immediate forms
            6'h03, 6'h08, 6'h0a, 6'h0c, 6'h0d, 6'h0e, 6'h0f, 6'h14: wr = 1'b1;
            // trap opcode 11 hex and unknown opcodes retire silently
            default: wr = 1'b0;
        endcase
        return wr;
    endfunction

    // compares the result about to transfer with the next expected line
    task automatic checkResult();
        bit   good;
        logic expWrite;
        good = 1'b1;
        assert (resIdx < numTests) else begin
            $display("extra result with no test left: dest %0d value %h trap %0b",
                     res.destReg, res.value, res.trap);
            errCount++;
            good = 1'b0;
        end
        if (good) begin
            expWrite = writesReg(stimInst[resIdx]);
            assert (res.destReg == expDest[resIdx]) else begin
                $display("CHECK FAILED %s dest expected %0d actual %0d",
                         testName[resIdx], expDest[resIdx], res.destReg);
                good = 1'b0;
            end
            assert (res.value == expValue[resIdx]) else begin
                $display("CHECK FAILED %s value expected %h actual %h",
                         testName[resIdx], expValue[resIdx], res.value);
                good = 1'b0;
            end
            assert (res.trap == expTrap[resIdx]) else begin
                $display("CHECK FAILED %s trap expected %0b actual %0b",
                         testName[resIdx], expTrap[resIdx], res.trap);
                good = 1'b0;
            end
            assert (res.regWrite == expWrite) else begin
                $display("CHECK FAILED %s regWrite expected %0b actual %0b",
                         testName[resIdx], expWrite, res.regWrite);
                good = 1'b0;
            end
            if (good) begin
                okCount++;
                $display("test %s ok", testName[resIdx]);
            end else begin
                badCount++;
                $display("test %s mismatch", testName[resIdx]);
            end
        end
        resIdx++;
    endtask

    task automatic endRun();
        $display("tests %0d, ok %0d, mismatched %0d, other errors %0d",
                 numTests, okCount, badCount, errCount);
        if ((badCount == 0) && (errCount == 0) && (okCount == numTests)) begin
            $display("sim passed");
        end else begin
            $display("sim failed");
        end
        $finish;
    endtask

    ////////////////////
    // instruction driver
    ////////////////////

    initial begin
        bit accepted;
        instValid = 1'b0;
        inst      = '0;
        loadStim();
        loaded = 1'b1;
        wait (rstN === 1'b1);
        @(negedge clk);
        for (driveIdx = 0; driveIdx < numTests; driveIdx++) begin
            instValid        = 1'b1;
            inst.instruction = stimInst[driveIdx];
            inst.nextPC      = stimPC[driveIdx];
            accepted         = 1'b0;
            // ready is settled 1 ns after the falling edge
            while (!accepted) begin
                #1;
                accepted = instReady;
                @(negedge clk);
            end
        end
        instValid = 1'b0;
        inst      = '0;
        wait (resIdx >= numTests);
        repeat (DRAIN_CYCLES) @(negedge clk);
        endRun();
    end

    // back-pressure starts once half the results are back
    initial begin
        resReady = 1'b0;
        wait (rstN === 1'b1);
        forever begin
            @(negedge clk);
            if (resIdx >= (numTests / 2)) begin
                resReady = 1'($random(seed) & 1);
            end else begin
                resReady = 1'b1;
            end
        end
    end

    ////////////////////
    // monitor and watchdog
    ////////////////////

    // a result seen here transfers on the next rising edge
    initial begin
        wait (rstN === 1'b1);
        forever begin
            @(negedge clk);
            #1;
            if (resValid && resReady) begin
                checkResult();
            end
        end
    end

    initial begin
        wait (loaded);
        repeat (numTests * CYCLES_PER_TEST) @(posedge clk);
        $display("watchdog expired, only %0d of %0d results came back", resIdx, numTests);
        errCount++;
        endRun();
    end

endmodule

// File: sim/dlxStim.txt
# name instruction nextPC dest(decimal) value trap
# instruction, nextPC and value in hex
addiPos      20010064 00000004  1 00000064 0
addiNeg      2002FFFD 00000008  2 FFFFFFFD 0
oriZext      34038001 0000000C  3 00008001 0
addR         00222020 00000010  4 00000061 0
subR         00812822 00000014  5 FFFFFFFD 0
andR         00A33024 00000018  6 00008001 0
orR          00233825 0000001C  7 00008065 0
xorR         00E14026 00000020  8 00008001 0
addiShamt    20090004 00000024  9 00000004 0
sllR         00295004 00000028 10 00000640 0
srlR         00495806 0000002C 11 0FFFFFFF 0
sltR         0041602A 00000030 12 00000001 0
slliImm      506D0008 00000034 13 00800100 0
lhiUpper     3C0EABCD 00000038 14 ABCD0000 0
jalLink      0C000010 0000003C 31 0000003C 0
addLink      03E07820 00000040 15 0000003C 0
trapWord     44000300 00000044  0 00000300 1
oriAfterTrap 34300000 00000048 16 00000064 0
addiR0       20000055 0000004C  0 00000055 0
readR0       00098820 00000050 17 00000004 0
subiImm      28320014 00000054 18 00000050 0
andiImm      325300F0 00000058 19 00000050 0
xoriImm      3A74FFFF 0000005C 20 0000FFAF 0
sltNeg       0022A82A 00000060 21 00000000 0
nopUnknown   FC000000 00000064  0 00000000 0

// File: project.f
rtl/dlxPkg.sv
rtl/controlUnit.sv
rtl/regFile.sv
rtl/decodeStage.sv
rtl/stageReg.sv
rtl/executeStage.sv
rtl/resultStage.sv
rtl/dlxCore.sv
sim/clockGen.sv
sim/tbDlxCore.sv

// File: Bender.yml
package:
  name: dlx_core

sources:
  - rtl/dlxPkg.sv
  - rtl/controlUnit.sv
  - rtl/regFile.sv
  - rtl/decodeStage.sv
  - rtl/stageReg.sv
  - rtl/executeStage.sv
  - rtl/resultStage.sv
  - rtl/dlxCore.sv
  - target: simulation
    files:
      - sim/clockGen.sv
      - sim/tbDlxCore.sv
